// ==== hdl/phold_msg_pkg.sv ====
package phold_msg_pkg;

   parameter int TIME_WID   = 16;
   parameter int LPID_WID   = 3;
   parameter int OFFSET_WID = 8;
   parameter int RND_WID    = 8;

   typedef enum logic {
      EVT_REGULAR = 1'b0,
      EVT_CANCEL  = 1'b1
   } evt_kind_e;

   // Layout shared by input and output messages, 20 bits
   typedef struct packed {
      evt_kind_e             kind;
      logic [LPID_WID-1:0]   target;
      logic [TIME_WID-1:0]   tstamp;
   } event_msg_t;

   // One stored history record, 28 bits
   typedef struct packed {
      logic [LPID_WID-1:0]   target;   // Target of the event this one generated
      logic [OFFSET_WID-1:0] offset;   // Generated time minus own time
      evt_kind_e             kind;
      logic [TIME_WID-1:0]   tstamp;
   } hist_entry_t;

   // Null message, a cancel with zero target and time
   localparam event_msg_t NULL_MSG = '{
      kind:   EVT_CANCEL,
      target: '0,
      tstamp: '0
   };

endpackage

// ==== hdl/phold_ctrl_pkg.sv ====
package phold_ctrl_pkg;

   typedef enum logic [2:0] {
      ST_IDLE       = 3'd0,
      ST_READ_HIST  = 3'd1,
      ST_PROC_EVT   = 3'd2,
      ST_WRITE_HIST = 3'd3,
      ST_SEND_EVT   = 3'd4,
      ST_WAIT_ACK   = 3'd5
   } core_state_e;

   // Outcome of one history entry against the current event
   typedef enum logic [1:0] {
      V_KEEP      = 2'd0,
      V_EXPIRED   = 2'd1,
      V_CANCELLED = 2'd2,
      V_ROLLBACK  = 2'd3
   } verdict_e;

endpackage

// ==== hdl/fwft_fifo.sv ====
`timescale 1ns/1ps

module fwft_fifo #(
   parameter int DEPTH = 16
) (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       clear,
   input  logic                       push,
   input  phold_msg_pkg::hist_entry_t din,
   input  logic                       pop,
   output phold_msg_pkg::hist_entry_t dout,
   output logic                       empty,
   output logic                       full
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   phold_msg_pkg::hist_entry_t mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          push_ok;
   logic          pop_ok;

   assign empty   = (count == '0);
   assign full    = (count == (AW+1)'(DEPTH));
   assign push_ok = push && !full;    // Push on a full buffer is dropped
   assign pop_ok  = pop && !empty;
   assign dout    = mem[rd_ptr];      // Head shows without a pop

   always_ff @(posedge clk) begin
      if (push_ok)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_ok)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop_ok)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + (AW+1)'(push_ok) - (AW+1)'(pop_ok);
      end
   end

endmodule

// ==== hdl/hist_store.sv ====
`timescale 1ns/1ps

module hist_store #(
   parameter int HIST_DEPTH = 16
) (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic [phold_msg_pkg::LPID_WID-1:0]   lp_id,
   input  logic [$clog2(HIST_DEPTH+1)-1:0]      entry_idx,
   input  logic                                 rd_strobe,
   input  logic                                 wr_strobe,
   input  phold_msg_pkg::hist_entry_t           wr_entry,
   input  logic                                 wr_last,
   output phold_msg_pkg::hist_entry_t           rd_entry,
   output logic [$clog2(HIST_DEPTH+1)-1:0]      stored_cnt
);

   localparam int NUM_LP  = 2 ** phold_msg_pkg::LPID_WID;
   localparam int CNT_WID = $clog2(HIST_DEPTH + 1);
   localparam int AW      = $clog2(NUM_LP * HIST_DEPTH);

   phold_msg_pkg::hist_entry_t mem [NUM_LP * HIST_DEPTH];
   logic [CNT_WID-1:0] cnt [NUM_LP];
   logic [AW-1:0]      addr;

   // Each LP owns a block of HIST_DEPTH entries
   assign addr       = AW'(lp_id) * AW'(HIST_DEPTH) + AW'(entry_idx);
   assign stored_cnt = cnt[lp_id];

   always_ff @(posedge clk) begin
      if (wr_strobe)
         mem[addr] <= wr_entry;
      if (rd_strobe)
         rd_entry <= mem[addr];   // Registered read, one cycle later
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_LP; i++)
            cnt[i] <= '0;
      end else if (wr_last) begin
         cnt[lp_id] <= entry_idx;   // Index equals the number written
      end
   end

endmodule

// ==== hdl/hist_filter.sv ====
`timescale 1ns/1ps

module hist_filter (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic                                 start,
   input  phold_msg_pkg::event_msg_t            cur_evt,
   input  logic [phold_msg_pkg::TIME_WID-1:0]   gvt,
   input  logic                                 rd_valid,
   input  phold_msg_pkg::hist_entry_t           rd_entry,
   output logic                                 keep_push,
   output logic                                 rbk_push,
   output logic                                 discard_cur,
   output phold_msg_pkg::event_msg_t            cancel_msg
);

   logic                    entry_vld;    // Read data lands one cycle after its strobe
   logic                    match_q;
   phold_ctrl_pkg::verdict_e verdict;

   always_comb begin
      verdict = phold_ctrl_pkg::V_KEEP;
      if (rd_entry.tstamp < gvt) begin
         verdict = phold_ctrl_pkg::V_EXPIRED;
      end else if (rd_entry.kind != cur_evt.kind && rd_entry.tstamp == cur_evt.tstamp &&
                   !match_q) begin
         verdict = phold_ctrl_pkg::V_CANCELLED;
      end else if (cur_evt.kind == phold_msg_pkg::EVT_REGULAR &&
                   rd_entry.kind == phold_msg_pkg::EVT_REGULAR &&
                   rd_entry.tstamp > cur_evt.tstamp) begin
         verdict = phold_ctrl_pkg::V_ROLLBACK;   // Straggler, undo the later entry
      end
   end

   assign keep_push = entry_vld && (verdict == phold_ctrl_pkg::V_KEEP);
   assign rbk_push  = entry_vld && (verdict == phold_ctrl_pkg::V_ROLLBACK);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         entry_vld   <= 1'b0;
         match_q     <= 1'b0;
         discard_cur <= 1'b0;
         cancel_msg  <= phold_msg_pkg::NULL_MSG;
      end else begin
         entry_vld <= rd_valid;
         if (start) begin
            match_q     <= 1'b0;
            discard_cur <= 1'b0;
            cancel_msg  <= phold_msg_pkg::NULL_MSG;   // Stays null unless a match captures
         end else if (entry_vld && verdict == phold_ctrl_pkg::V_CANCELLED) begin
            match_q     <= 1'b1;   // Only one annihilation per event
            discard_cur <= 1'b1;
            // A cancel arriving late must also retract what the entry generated
            if (cur_evt.kind == phold_msg_pkg::EVT_CANCEL) begin
               cancel_msg.kind   <= phold_msg_pkg::EVT_CANCEL;
               cancel_msg.target <= rd_entry.target;
               cancel_msg.tstamp <= rd_entry.tstamp +
                                    phold_msg_pkg::TIME_WID'(rd_entry.offset);
            end
         end
      end
   end

endmodule

// ==== hdl/event_gen.sv ====
`timescale 1ns/1ps

module event_gen #(
   parameter int MIN_GAP = 10
) (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic                                gen_strobe,
   input  logic                                discard_cur,
   input  phold_msg_pkg::event_msg_t           cur_evt,
   input  logic [phold_msg_pkg::RND_WID-1:0]   rnd,
   output logic                                rec_push,
   output phold_msg_pkg::hist_entry_t          rec,
   output phold_msg_pkg::event_msg_t           new_msg
);

   localparam int TW = phold_msg_pkg::TIME_WID;

   logic [TW-1:0] gap;
   logic [TW-1:0] new_time;

   assign gap      = TW'(MIN_GAP) + TW'(rnd[4:0]);   // Gap never below MIN_GAP
   assign new_time = cur_evt.tstamp + gap;

   // History record of the event processed now
   assign rec.target = rnd[phold_msg_pkg::RND_WID-1 -: phold_msg_pkg::LPID_WID];
   assign rec.offset = gap[phold_msg_pkg::OFFSET_WID-1:0];
   assign rec.kind   = cur_evt.kind;
   assign rec.tstamp = cur_evt.tstamp;
   assign rec_push   = gen_strobe && !discard_cur;   // Annihilated events leave no trace

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         new_msg <= '0;
      end else if (gen_strobe) begin
         new_msg.kind   <= phold_msg_pkg::EVT_REGULAR;
         new_msg.target <= rec.target;
         new_msg.tstamp <= new_time;
      end
   end

endmodule

// ==== hdl/msg_sequencer.sv ====
`timescale 1ns/1ps

module msg_sequencer (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       start,
   input  logic                       discard_cur,
   input  phold_msg_pkg::event_msg_t  cancel_msg,
   input  phold_msg_pkg::event_msg_t  new_msg,
   input  phold_msg_pkg::event_msg_t  cur_evt,
   input  phold_msg_pkg::hist_entry_t rbk_head,
   input  logic                       rbk_empty,
   input  logic                       ack,
   output logic                       rbk_pop,
   output phold_msg_pkg::event_msg_t  out_msg,
   output logic                       out_valid,
   output logic                       done
);

   logic                      pair_phase;   // Set while the cancel half of a pair is out
   logic                      acked;
   phold_msg_pkg::event_msg_t primary;

   always_comb begin
      if (discard_cur)
         primary = cancel_msg;   // Null unless the filter captured one
      else if (cur_evt.kind == phold_msg_pkg::EVT_CANCEL)
         primary = phold_msg_pkg::NULL_MSG;
      else
         primary = new_msg;
   end

   assign acked   = out_valid && ack;
   assign rbk_pop = acked && pair_phase;   // Entry consumed when its re-issue goes out
   assign done    = acked && !pair_phase && rbk_empty;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid  <= 1'b0;
         pair_phase <= 1'b0;
         out_msg    <= '0;
      end else if (start) begin
         out_valid  <= 1'b1;
         pair_phase <= 1'b0;
         out_msg    <= primary;
      end else if (acked) begin
         if (pair_phase) begin
            pair_phase     <= 1'b0;
            out_msg.kind   <= phold_msg_pkg::EVT_REGULAR;
            out_msg.target <= cur_evt.target;
            out_msg.tstamp <= rbk_head.tstamp;
         end else if (!rbk_empty) begin
            pair_phase     <= 1'b1;
            out_msg.kind   <= phold_msg_pkg::EVT_CANCEL;
            out_msg.target <= rbk_head.target;
            out_msg.tstamp <= rbk_head.tstamp +
                              phold_msg_pkg::TIME_WID'(rbk_head.offset);
         end else begin
            out_valid <= 1'b0;
         end
      end
   end

endmodule

// ==== hdl/phold_ctrl.sv ====
`timescale 1ns/1ps

module phold_ctrl #(
   parameter int HIST_DEPTH = 16
) (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic                                 evt_valid,
   input  logic [phold_msg_pkg::LPID_WID-1:0]   evt_lp,
   input  logic [$clog2(HIST_DEPTH+1)-1:0]      stored_cnt,
   input  logic                                 keep_empty,
   input  logic                                 seq_done,
   output logic                                 ready,
   output logic                                 rd_strobe,
   output logic                                 wr_strobe,
   output logic                                 wr_last,
   output logic [$clog2(HIST_DEPTH+1)-1:0]      entry_idx,
   output logic                                 gen_strobe,
   output logic                                 keep_pop,
   output logic                                 seq_start,
   output logic [phold_msg_pkg::LPID_WID-1:0]   lp_id
);

   localparam int CNT_WID = $clog2(HIST_DEPTH + 1);

   phold_ctrl_pkg::core_state_e state_q;
   logic [CNT_WID-1:0]                  idx_q;
   logic [phold_msg_pkg::LPID_WID-1:0]  lp_q;
   logic                                writing;

   assign ready   = (state_q == phold_ctrl_pkg::ST_IDLE);
   // In idle the store is addressed by the incoming LP so entry 0 is read at accept
   assign lp_id     = ready ? evt_lp : lp_q;
   assign entry_idx = ready ? '0 : idx_q;

   assign writing    = (state_q == phold_ctrl_pkg::ST_WRITE_HIST);
   assign wr_strobe  = writing && !keep_empty;
   assign keep_pop   = wr_strobe;
   assign wr_last    = writing && keep_empty;   // Commits the new count
   assign seq_start  = wr_last;
   assign gen_strobe = (state_q == phold_ctrl_pkg::ST_PROC_EVT);

   always_comb begin
      rd_strobe = 1'b0;
      if (ready)
         rd_strobe = evt_valid && (stored_cnt != '0);
      else if (state_q == phold_ctrl_pkg::ST_READ_HIST)
         rd_strobe = (idx_q < stored_cnt);
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= phold_ctrl_pkg::ST_IDLE;
         idx_q   <= '0;
         lp_q    <= '0;
      end else begin
         case (state_q)
            phold_ctrl_pkg::ST_IDLE: begin
               if (evt_valid) begin
                  lp_q    <= evt_lp;
                  idx_q   <= CNT_WID'(rd_strobe);
                  state_q <= phold_ctrl_pkg::ST_READ_HIST;
               end
            end
            phold_ctrl_pkg::ST_READ_HIST: begin
               idx_q <= idx_q + CNT_WID'(rd_strobe);
               if (idx_q >= stored_cnt)   // Last read data arrives this cycle
                  state_q <= phold_ctrl_pkg::ST_PROC_EVT;
            end
            phold_ctrl_pkg::ST_PROC_EVT: begin
               idx_q   <= '0;
               state_q <= phold_ctrl_pkg::ST_WRITE_HIST;
            end
            phold_ctrl_pkg::ST_WRITE_HIST: begin
               if (!keep_empty)
                  idx_q <= idx_q + 1'b1;
               else
                  state_q <= phold_ctrl_pkg::ST_SEND_EVT;
            end
            phold_ctrl_pkg::ST_SEND_EVT: begin
               state_q <= seq_done ? phold_ctrl_pkg::ST_IDLE : phold_ctrl_pkg::ST_WAIT_ACK;
               idx_q   <= '0;
            end
            phold_ctrl_pkg::ST_WAIT_ACK: begin
               if (seq_done)
                  state_q <= phold_ctrl_pkg::ST_IDLE;
            end
            default: state_q <= phold_ctrl_pkg::ST_IDLE;
         endcase
      end
   end

endmodule

// ==== hdl/phold_core.sv ====
`timescale 1ns/1ps

module phold_core #(
   parameter int HIST_DEPTH = 16,
   parameter int MIN_GAP    = 10
) (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic                                evt_valid,
   input  phold_msg_pkg::event_msg_t           evt_in,
   input  logic [phold_msg_pkg::TIME_WID-1:0]  gvt,
   input  logic [phold_msg_pkg::RND_WID-1:0]   rnd,
   output logic                                ready,
   output phold_msg_pkg::event_msg_t           out_msg,
   output logic                                out_valid,
   input  logic                                ack
);

   localparam int CNT_WID = $clog2(HIST_DEPTH + 1);

   logic                                accept;
   phold_msg_pkg::event_msg_t           cur_evt;
   logic [phold_msg_pkg::TIME_WID-1:0]  gvt_q;
   logic [phold_msg_pkg::RND_WID-1:0]   rnd_q;
   logic                                rd_strobe, wr_strobe, wr_last;
   logic                                gen_strobe, keep_pop, seq_start, seq_done;
   logic [CNT_WID-1:0]                  entry_idx, stored_cnt;
   logic [phold_msg_pkg::LPID_WID-1:0]  lp_id;
   phold_msg_pkg::hist_entry_t          rd_entry, gen_rec, keep_din, keep_head, rbk_head;
   logic                                keep_push, rbk_push, rec_push, rbk_pop;
   logic                                keep_empty, rbk_empty;
   logic                                discard_cur;
   phold_msg_pkg::event_msg_t           cancel_msg, new_msg;

   assign accept = evt_valid && ready;

   // Event context held for the whole processing pass
   always_ff @(posedge clk) begin
      if (accept) begin
         cur_evt <= evt_in;
         gvt_q   <= gvt;
         rnd_q   <= rnd;
      end
   end

   // Filter and generator never push in the same cycle
   assign keep_din = rec_push ? gen_rec : rd_entry;

   phold_ctrl #(.HIST_DEPTH(HIST_DEPTH)) i_ctrl (
      .clk, .arst_n, .evt_valid, .evt_lp(evt_in.target), .stored_cnt, .keep_empty,
      .seq_done, .ready, .rd_strobe, .wr_strobe, .wr_last, .entry_idx, .gen_strobe,
      .keep_pop, .seq_start, .lp_id
   );

   hist_store #(.HIST_DEPTH(HIST_DEPTH)) i_hist_store (
      .clk, .arst_n, .lp_id, .entry_idx, .rd_strobe, .wr_strobe,
      .wr_entry(keep_head), .wr_last, .rd_entry, .stored_cnt
   );

   hist_filter i_hist_filter (
      .clk, .arst_n, .start(accept), .cur_evt, .gvt(gvt_q), .rd_valid(rd_strobe),
      .rd_entry, .keep_push, .rbk_push, .discard_cur, .cancel_msg
   );

   event_gen #(.MIN_GAP(MIN_GAP)) i_event_gen (
      .clk, .arst_n, .gen_strobe, .discard_cur, .cur_evt, .rnd(rnd_q),
      .rec_push, .rec(gen_rec), .new_msg
   );

   fwft_fifo #(.DEPTH(HIST_DEPTH)) keep_buf (
      .clk, .arst_n, .clear(accept), .push(keep_push || rec_push), .din(keep_din),
      .pop(keep_pop), .dout(keep_head), .empty(keep_empty), .full()
   );

   fwft_fifo #(.DEPTH(HIST_DEPTH)) rbk_buf (
      .clk, .arst_n, .clear(accept), .push(rbk_push), .din(rd_entry),
      .pop(rbk_pop), .dout(rbk_head), .empty(rbk_empty), .full()
   );

   msg_sequencer i_msg_sequencer (
      .clk, .arst_n, .start(seq_start), .discard_cur, .cancel_msg, .new_msg, .cur_evt,
      .rbk_head, .rbk_empty, .ack, .rbk_pop, .out_msg, .out_valid, .done(seq_done)
   );

endmodule

// ==== verif/phold_assert.sv ====
`timescale 1ns/1ps

module phold_assert (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      ready,
   input  logic                      out_valid,
   input  phold_msg_pkg::event_msg_t out_msg,
   input  logic                      ack
);

   int fail_cnt = 0;

   // Message frozen until the ack takes it
   msg_held: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !ack |=> $stable(out_msg))
      else begin
         $error("out_msg changed while out_valid was high and ack was low");
         fail_cnt++;
      end

   no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
      !(ready && out_valid))
      else begin
         $error("ready and out_valid are high in the same cycle");
         fail_cnt++;
      end

   // Idle and silent while reset is held
   reset_state: assert property (@(posedge clk) !arst_n |-> ready && !out_valid)
      else begin
         $error("ready low or out_valid high during reset");
         fail_cnt++;
      end

endmodule

// ==== verif/phold_checker.sv ====
`timescale 1ns/1ps

module phold_checker (
   input  logic                      clk,
   input  logic                      arst_n,
   input  phold_msg_pkg::event_msg_t out_msg,
   input  logic                      out_valid,
   input  logic                      ready,
   input  logic                      exp_valid,
   input  phold_msg_pkg::event_msg_t exp_msg,
   input  logic [3:0]                ack_delay,
   output logic                      ack,
   output int                        pending,
   output int                        mismatch_cnt,
   output int                        other_cnt,
   output int                        seen_cnt
);

   phold_msg_pkg::event_msg_t exp_q [$];
   phold_msg_pkg::event_msg_t held;
   phold_msg_pkg::event_msg_t want;
   logic                      held_vld;
   int                        wait_left;

   initial begin
      ack          = 1'b0;
      held_vld     = 1'b0;
      wait_left    = 0;
      pending      = 0;
      mismatch_cnt = 0;
      other_cnt    = 0;
      seen_cnt     = 0;
      forever begin
         @(posedge clk);
         if (exp_valid)
            exp_q.push_back(exp_msg);   // Driven well before this edge
         pending = exp_q.size();
         #5;
         if (!arst_n) begin
            ack      = 1'b0;
            held_vld = 1'b0;
         end else begin
            if (ack) begin   // Taken by the DUT at this edge
               ack      = 1'b0;
               held_vld = 1'b0;
            end
            if (out_valid && !held_vld) begin
               seen_cnt++;
               if (exp_q.size() == 0) begin
                  other_cnt++;
                  $display("Unexpected output message 0x%05h, none was expected", out_msg);
               end else begin
                  want = exp_q.pop_front();
                  if (out_msg !== want) begin
                     mismatch_cnt++;
                     $display("MISMATCH out_msg: got 0x%05h, expected 0x%05h", out_msg, want);
                  end
               end
               pending   = exp_q.size();
               held      = out_msg;
               held_vld  = 1'b1;
               wait_left = int'(ack_delay);
            end else if (held_vld && out_msg !== held) begin
               other_cnt++;
               $display("Output message changed while it waited for its ack");
            end
            if (held_vld && !out_valid) begin
               other_cnt++;
               $display("out_valid dropped before the message was acked");
            end
            if (held_vld && ready) begin
               other_cnt++;
               $display("ready went high while a message still waited for its ack");
            end
            if (held_vld) begin
               if (wait_left == 0)
                  ack = 1'b1;
               else
                  wait_left--;
            end
         end
      end
   end

endmodule

// ==== verif/phold_tb.sv ====
`timescale 1ns/1ps

module phold_tb;

   localparam int HIST_DEPTH    = 16;
   localparam int MIN_GAP       = 10;
   localparam int TW            = phold_msg_pkg::TIME_WID;
   localparam int LW            = phold_msg_pkg::LPID_WID;
   localparam int NUM_LP        = 2 ** LW;
   localparam int WAIT_LIMIT    = 500;
   localparam int RANDOM_EVENTS = 60;

   logic                      clk = 1'b0;
   logic                      arst_n;
   logic                      evt_valid;
   phold_msg_pkg::event_msg_t evt_in;
   logic [TW-1:0]             gvt;
   logic [7:0]                rnd;
   logic                      ready;
   phold_msg_pkg::event_msg_t out_msg;
   logic                      out_valid;
   logic                      ack;
   logic                      exp_valid;
   phold_msg_pkg::event_msg_t exp_msg;
   logic [3:0]                ack_delay;
   int                        pending, mismatch_cnt, other_cnt, seen_cnt;
   int                        timeout_cnt;
   logic [31:0]               lfsr;

   // Reference history, one list per LP
   phold_msg_pkg::hist_entry_t ref_hist [NUM_LP][HIST_DEPTH];
   int                         ref_cnt [NUM_LP];
   phold_msg_pkg::event_msg_t  exp_q [$];

   always #20 clk = ~clk;

   phold_core #(.HIST_DEPTH(HIST_DEPTH), .MIN_GAP(MIN_GAP)) i_dut (
      .clk, .arst_n, .evt_valid, .evt_in, .gvt, .rnd, .ready, .out_msg, .out_valid, .ack
   );

   phold_checker i_checker (
      .clk, .arst_n, .out_msg, .out_valid, .ready, .exp_valid, .exp_msg, .ack_delay,
      .ack, .pending, .mismatch_cnt, .other_cnt, .seen_cnt
   );

   bind phold_core phold_assert i_assert (.clk, .arst_n, .ready, .out_valid, .out_msg, .ack);

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] take_bits(int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   // Sorts the LP history, updates it and queues the expected messages
   function automatic void predict_msgs(phold_msg_pkg::event_msg_t ev, logic [TW-1:0] gv,
                                        logic [7:0] rn);
      phold_msg_pkg::hist_entry_t kept [$];
      phold_msg_pkg::hist_entry_t rbk [$];
      phold_msg_pkg::hist_entry_t e;
      phold_msg_pkg::event_msg_t  first;
      logic                       matched;
      logic [TW-1:0]              gap;
      int                         lp;
      lp      = int'(ev.target);
      matched = 1'b0;
      first   = '{kind: phold_msg_pkg::EVT_CANCEL, target: '0, tstamp: '0};
      gap     = TW'(MIN_GAP) + TW'(rn[4:0]);
      for (int i = 0; i < ref_cnt[lp]; i++) begin
         e = ref_hist[lp][i];
         if (e.tstamp < gv) begin
            // Expired entry is dropped
         end else if (e.kind != ev.kind && e.tstamp == ev.tstamp && !matched) begin
            matched = 1'b1;
            if (ev.kind == phold_msg_pkg::EVT_CANCEL)
               first = '{kind: phold_msg_pkg::EVT_CANCEL, target: e.target,
                         tstamp: e.tstamp + TW'(e.offset)};
         end else if (ev.kind == phold_msg_pkg::EVT_REGULAR &&
                      e.kind == phold_msg_pkg::EVT_REGULAR && e.tstamp > ev.tstamp) begin
            rbk.push_back(e);
         end else begin
            kept.push_back(e);
         end
      end
      if (!matched) begin
         if (kept.size() < HIST_DEPTH)
            kept.push_back('{target: rn[7:5], offset: gap[7:0], kind: ev.kind,
                             tstamp: ev.tstamp});
         if (ev.kind == phold_msg_pkg::EVT_REGULAR)
            first = '{kind: phold_msg_pkg::EVT_REGULAR, target: rn[7:5],
                      tstamp: ev.tstamp + gap};
      end
      for (int i = 0; i < kept.size(); i++)
         ref_hist[lp][i] = kept[i];
      ref_cnt[lp] = kept.size();
      exp_q.push_back(first);
      foreach (rbk[i]) begin
         exp_q.push_back('{kind: phold_msg_pkg::EVT_CANCEL, target: rbk[i].target,
                           tstamp: rbk[i].tstamp + TW'(rbk[i].offset)});
         exp_q.push_back('{kind: phold_msg_pkg::EVT_REGULAR, target: ev.target,
                           tstamp: rbk[i].tstamp});
      end
   endfunction

   task automatic wait_idle();
      int n;
      n = 0;
      while (timeout_cnt == 0 && !(ready && !out_valid && pending == 0) &&
             n < WAIT_LIMIT) begin
         @(posedge clk);
         #5;
         n++;
      end
      if (n == WAIT_LIMIT) begin
         timeout_cnt++;
         $display("Timeout while waiting for the core to finish its messages");
      end
   endtask

   task automatic send_event(phold_msg_pkg::evt_kind_e k, int lp, int t, int gv,
                             logic [3:0] dly);
      phold_msg_pkg::event_msg_t ev;
      logic [7:0]                rn;
      ev = '{kind: k, target: LW'(lp), tstamp: TW'(t)};
      rn = 8'(take_bits(8));
      wait_idle();
      predict_msgs(ev, TW'(gv), rn);
      while (exp_q.size() > 0) begin   // Hand the expected list to the checker
         exp_valid = 1'b1;
         exp_msg   = exp_q.pop_front();
         @(posedge clk);
         #5;
      end
      exp_valid = 1'b0;
      ack_delay = dly;
      evt_in    = ev;
      gvt       = TW'(gv);
      rnd       = rn;
      evt_valid = 1'b1;
      @(posedge clk);
      #5;
      evt_valid = 1'b0;
   endtask

   // The core must ignore this one
   task automatic strobe_while_busy();
      evt_in    = '{kind: phold_msg_pkg::EVT_REGULAR, target: LW'(5), tstamp: TW'(1)};
      evt_valid = !ready;
      @(posedge clk);
      #5;
      evt_valid = 1'b0;
   endtask

   initial begin
      phold_msg_pkg::evt_kind_e r_kind;
      int                       r_lp, r_time, r_gvt;
      logic [3:0]               r_dly;
      arst_n      = 1'b0;
      evt_valid   = 1'b0;
      evt_in      = '0;
      gvt         = '0;
      rnd         = '0;
      exp_valid   = 1'b0;
      exp_msg     = '0;
      ack_delay   = '0;
      timeout_cnt = 0;
      lfsr        = 32'h9ee1_16ab;
      for (int i = 0; i < NUM_LP; i++)
         ref_cnt[i] = 0;
      repeat (8) @(posedge clk);
      #5;
      arst_n = 1'b1;

      send_event(phold_msg_pkg::EVT_REGULAR, 1, 100, 0, 4'd0);   // Empty LP
      // Cancel against a stored regular and then regular against a stored cancel
      send_event(phold_msg_pkg::EVT_CANCEL, 1, 100, 0, 4'd1);
      send_event(phold_msg_pkg::EVT_CANCEL, 2, 200, 0, 4'd2);
      send_event(phold_msg_pkg::EVT_REGULAR, 2, 200, 0, 4'd3);
      // Entries at 50 and 60 expire so the straggler at 40 sees only one entry
      send_event(phold_msg_pkg::EVT_REGULAR, 3, 50, 0, 4'd1);
      send_event(phold_msg_pkg::EVT_REGULAR, 3, 60, 0, 4'd0);
      send_event(phold_msg_pkg::EVT_REGULAR, 3, 300, 100, 4'd2);
      send_event(phold_msg_pkg::EVT_REGULAR, 3, 40, 0, 4'd1);
      // Straggler rolls back three entries under a slow ack
      send_event(phold_msg_pkg::EVT_REGULAR, 4, 500, 0, 4'd0);
      send_event(phold_msg_pkg::EVT_REGULAR, 4, 510, 0, 4'd3);
      send_event(phold_msg_pkg::EVT_REGULAR, 4, 520, 0, 4'd0);
      send_event(phold_msg_pkg::EVT_REGULAR, 4, 450, 0, 4'd9);
      strobe_while_busy();

      for (int k = 0; k < RANDOM_EVENTS; k++) begin
         r_kind = (take_bits(1) == 32'd1) ? phold_msg_pkg::EVT_CANCEL
                                          : phold_msg_pkg::EVT_REGULAR;
         r_lp   = int'(take_bits(3));
         r_time = 60 + 4 * int'(take_bits(4));   // Narrow range so times collide
         r_gvt  = int'(take_bits(6));
         r_dly  = 4'(take_bits(2));
         send_event(r_kind, r_lp, r_time, r_gvt, r_dly);
      end
      wait_idle();

      $write("Checked %0d messages: %0d mismatches, %0d other errors, ", seen_cnt,
             mismatch_cnt, other_cnt);
      $display("%0d timeouts, %0d assertion failures", timeout_cnt,
               i_dut.i_assert.fail_cnt);
      if (mismatch_cnt + other_cnt + timeout_cnt + i_dut.i_assert.fail_cnt == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// ==== sources.f ====
hdl/phold_msg_pkg.sv
hdl/phold_ctrl_pkg.sv
hdl/fwft_fifo.sv
hdl/hist_store.sv
hdl/hist_filter.sv
hdl/event_gen.sv
hdl/msg_sequencer.sv
hdl/phold_ctrl.sv
hdl/phold_core.sv
verif/phold_assert.sv
verif/phold_checker.sv
verif/phold_tb.sv

// ==== Bender.yml ====
package:
  name: phold_core

sources:
  - hdl/phold_msg_pkg.sv
  - hdl/phold_ctrl_pkg.sv
  - hdl/fwft_fifo.sv
  - hdl/hist_store.sv
  - hdl/hist_filter.sv
  - hdl/event_gen.sv
  - hdl/msg_sequencer.sv
  - hdl/phold_ctrl.sv
  - hdl/phold_core.sv
  - target: test
    files:
      - verif/phold_assert.sv
      - verif/phold_checker.sv
      - verif/phold_tb.sv
